// ==== flist.f ====
logic/elem_pkg.sv
logic/elem_cfg_regs.sv
logic/elem_operand_shift.sv
logic/elem_reduce_alu.sv
logic/elem_unit_top.sv
test/elem_tb_clock.sv
test/elem_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then judge the run from sim.log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module elem_tb -f flist.f > sim.log 2>&1 &&
    ./obj_dir/Velem_tb >> sim.log 2>&1 ||
    echo "build or simulation returned an error status" >> sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "no pass line found in sim.log"; exit 1; }
echo "simulation passed"
exit 0

// ==== test/elem_tb.sv ====
// testbench for the vector element reduction unit
// programs jobs over Wishbone, models the register file and checks every write-back

module elem_tb;

    localparam int unsigned VREG_W          = 128;
    localparam int unsigned CLK_PERIOD      = 8;
    localparam int unsigned NUM_JOBS        = 48;
    localparam int unsigned WATCHDOG_CYCLES = NUM_JOBS * (VREG_W / 8 + 20) + 500;

    logic                              clk;
    logic                              rst_n;
    elem_pkg::wb_req_t                 wb_req;
    elem_pkg::wb_rsp_t                 wb_rsp;
    logic [elem_pkg::VREG_ADDR_W-1:0]  vreg_rd_addr;
    logic [VREG_W-1:0]                 vreg_rd;
    logic                              xreg_valid;
    logic [elem_pkg::XLEN-1:0]         xreg;

    logic [VREG_W-1:0]                 vregs [32];
    logic [elem_pkg::VREG_ADDR_W-1:0]  addr_seen;
    logic [31:0]                       exp_res [$];
    logic [4:0]                        exp_vs [$];
    logic [31:0]                       last_xreg;
    int                                wb_seen;
    int                                jobs_issued;
    int                                checks;
    int                                errors;

    elem_tb_clock #(
        .PERIOD     (CLK_PERIOD),
        .RST_CYCLES (2)
    ) clock_i (
        .clk_o      (clk),
        .rst_n_o    (rst_n)
    );

    elem_unit_top #(
        .VREG_W         (VREG_W)
    ) dut_i (
        .clk_i          (clk),
        .async_rst_ni   (rst_n),
        .wb_req_i       (wb_req),
        .wb_rsp_o       (wb_rsp),
        .vreg_rd_addr_o (vreg_rd_addr),
        .vreg_rd_i      (vreg_rd),
        .xreg_valid_o   (xreg_valid),
        .xreg_o         (xreg)
    );

    ////////////////////////////////////////
    // helpers and reference model

    function automatic int elem_width(input elem_pkg::elem_sew_e sew);
        case (sew)
            elem_pkg::SEW_16: return 16;
            elem_pkg::SEW_32: return 32;
            default:          return 8;
        endcase
    endfunction

    function automatic logic [31:0] width_mask(input elem_pkg::elem_sew_e sew);
        return (elem_width(sew) == 32) ? 32'hffff_ffff : ((32'h1 << elem_width(sew)) - 1);
    endfunction

    function automatic int elem_count(input elem_pkg::elem_sew_e sew);
        return VREG_W / elem_width(sew);
    endfunction

    // two's complement value of the low w bits
    function automatic longint as_signed(input logic [31:0] v, input int w);
        longint x;
        x = longint'(v);
        if (v[w-1]) begin
            x = x - (longint'(1) << w);
        end
        return x;
    endfunction

    function automatic logic [31:0] ctrl_word(input elem_pkg::elem_op_e op,
                                              input elem_pkg::elem_sew_e sew,
                                              input logic [4:0] vs, input logic start);
        return {start, 18'b0, vs, 2'b0, sew, op};
    endfunction

    // expected scalar: fold elements below vl on the low SEW bits, keep the upper init bits
    function automatic logic [31:0] ref_reduce(input elem_pkg::elem_op_e op,
                                               input elem_pkg::elem_sew_e sew,
                                               input logic [7:0] vl, input logic [31:0] init,
                                               input logic [VREG_W-1:0] vreg);
        int          w;
        int          i;
        logic [31:0] mask;
        logic [31:0] acc;
        logic [31:0] e;
        w    = elem_width(sew);
        mask = width_mask(sew);
        acc  = init & mask;
        for (i = 0; i < elem_count(sew); i++) begin
            if (i < int'(vl)) begin
                e = 32'(vreg >> (i * w)) & mask;
                case (op)
                    elem_pkg::RED_SUM:  acc = (acc + e) & mask;
                    elem_pkg::RED_AND:  acc = acc & e;
                    elem_pkg::RED_OR:   acc = acc | e;
                    elem_pkg::RED_XOR:  acc = acc ^ e;
                    elem_pkg::RED_MINU: acc = (e < acc) ? e : acc;
                    elem_pkg::RED_MIN:  acc = (as_signed(e, w) < as_signed(acc, w)) ? e : acc;
                    elem_pkg::RED_MAXU: acc = (e > acc) ? e : acc;
                    default:            acc = (as_signed(e, w) > as_signed(acc, w)) ? e : acc;
                endcase
            end
        end
        return (init & ~mask) | acc;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // Wishbone master, inputs change on the falling edge

    task automatic wb_cycle(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
        @(negedge clk);
        wb_req = '{1'b1, 1'b1, we, adr, wdat};
        @(negedge clk);
        while (!wb_rsp.ack) begin
            @(negedge clk);
        end
        rdat = wb_rsp.dat;
        // stb stays up through the ack cycle and drops in the next one
        @(negedge clk);
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic read_expect(input logic [7:0] adr, input logic [31:0] exp, input string name);
        logic [31:0] rdat;
        wb_cycle(1'b0, adr, 32'h0, rdat);
        compare_value(name, rdat, exp);
    endtask

    task automatic start_job(input elem_pkg::elem_op_e op, input elem_pkg::elem_sew_e sew,
                             input logic [7:0] vl, input logic [4:0] vs, input logic [31:0] init);
        exp_res.push_back(ref_reduce(op, sew, vl, init, vregs[vs]));
        exp_vs.push_back(vs);
        jobs_issued++;
        wb_write(elem_pkg::REG_VL, {24'b0, vl});
        wb_write(elem_pkg::REG_INIT, init);
        wb_write(elem_pkg::REG_CTRL, ctrl_word(op, sew, vs, 1'b1));
    endtask

    // the watchdog bounds this wait
    task automatic wait_job(output logic [31:0] res);
        wait (wb_seen >= jobs_issued);
        res = last_xreg;
    endtask

    task automatic run_job(input elem_pkg::elem_op_e op, input elem_pkg::elem_sew_e sew,
                           input logic [7:0] vl, input logic [4:0] vs, input logic [31:0] init,
                           output logic [31:0] res);
        start_job(op, sew, vl, vs, init);
        wait_job(res);
    endtask

    // odd elements negative, even elements positive
    task automatic fill_signed_mix(input int idx, input elem_pkg::elem_sew_e sew);
        logic [VREG_W-1:0] v;
        logic [31:0]       e;
        int                i;
        v = '0;
        for (i = 0; i < elem_count(sew); i++) begin
            e = $urandom & (width_mask(sew) >> 1);
            if (i % 2 == 1) begin
                e = e | (32'h1 << (elem_width(sew) - 1));
            end
            v = v | (VREG_W'(e) << (i * elem_width(sew)));
        end
        vregs[idx] = v;
    endtask

    ////////////////////////////////////////
    // register file model and write-back checker

    always @(negedge clk) begin
        vreg_rd   = vregs[addr_seen];
        addr_seen = vreg_rd_addr;
    end

    always @(negedge clk) begin
        if (rst_n && xreg_valid) begin
            if (exp_res.size() == 0) begin
                $display("Scalar write-back at %0t with no job outstanding", $time);
                errors++;
            end else begin
                compare_value("xreg_o", xreg, exp_res.pop_front());
                compare_value("vreg_rd_addr_o", 32'(vreg_rd_addr), 32'(exp_vs.pop_front()));
            end
            last_xreg = xreg;
            wb_seen++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the jobs did not finish", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [31:0]         res_a;
        logic [31:0]         res_b;
        logic [31:0]         init;
        int                  s;
        int                  o;
        elem_pkg::elem_sew_e sew;
        wb_req    = '0;
        vreg_rd   = '0;
        addr_seen = '0;
        void'($urandom(32'h90cd));
        for (s = 0; s < 32; s++) begin
            for (o = 0; o < VREG_W / 32; o++) begin
                vregs[s][o*32 +: 32] = $urandom;
            end
        end
        wait (rst_n === 1'b1);

        // every opcode at every width, full vector
        for (s = 0; s < 3; s++) begin
            sew = elem_pkg::elem_sew_e'(s);
            for (o = 0; o < 8; o++) begin
                run_job(elem_pkg::elem_op_e'(o), sew, 8'(elem_count(sew)),
                        5'($urandom_range(31, 0)), $urandom, res_a);
            end
        end

        // partial vl, vl beyond the element count, and vl 0
        init = $urandom;
        run_job(elem_pkg::RED_SUM, elem_pkg::SEW_8, 8'd0, 5'd7, init, res_a);
        compare_value("xreg_o with vl 0", res_a, init);
        run_job(elem_pkg::RED_MAXU, elem_pkg::SEW_8, 8'd1, 5'd8, $urandom, res_a);
        run_job(elem_pkg::RED_XOR, elem_pkg::SEW_8, 8'd5, 5'd11, $urandom, res_a);
        run_job(elem_pkg::RED_MIN, elem_pkg::SEW_16, 8'd3, 5'd12, $urandom, res_a);
        run_job(elem_pkg::RED_SUM, elem_pkg::SEW_32, 8'd2, 5'd13, $urandom, res_a);
        run_job(elem_pkg::RED_OR, elem_pkg::SEW_8, 8'd200, 5'd14, $urandom, res_a);

        // signed and unsigned compare on elements with the top bit set
        for (s = 0; s < 3; s++) begin
            sew = elem_pkg::elem_sew_e'(s);
            fill_signed_mix(30, sew);
            init = $urandom | width_mask(sew);
            run_job(elem_pkg::RED_MINU, sew, 8'(elem_count(sew)), 5'd30, init, res_a);
            run_job(elem_pkg::RED_MIN, sew, 8'(elem_count(sew)), 5'd30, init, res_b);
            compare_value("min signed differs from unsigned", 32'(res_a != res_b), 32'd1);
            init = $urandom & ~width_mask(sew);
            run_job(elem_pkg::RED_MAXU, sew, 8'(elem_count(sew)), 5'd30, init, res_a);
            run_job(elem_pkg::RED_MAX, sew, 8'(elem_count(sew)), 5'd30, init, res_b);
            compare_value("max signed differs from unsigned", 32'(res_a != res_b), 32'd1);
        end

        // register readback, status during and after a job
        start_job(elem_pkg::RED_XOR, elem_pkg::SEW_16, 8'd5, 5'd19, 32'h5a5a_c3c3);
        read_expect(elem_pkg::REG_STATUS, 32'h1, "STATUS while busy");
        read_expect(elem_pkg::REG_CTRL, ctrl_word(elem_pkg::RED_XOR, elem_pkg::SEW_16, 5'd19, 1'b0),
                    "CTRL");
        read_expect(elem_pkg::REG_VL, 32'd5, "VL");
        read_expect(elem_pkg::REG_INIT, 32'h5a5a_c3c3, "INIT");
        wait_job(res_a);
        read_expect(elem_pkg::REG_STATUS, 32'h2, "STATUS after job");
        read_expect(elem_pkg::REG_RESULT, res_a, "RESULT");

        // a second start while busy must be dropped
        start_job(elem_pkg::RED_SUM, elem_pkg::SEW_8, 8'(elem_count(elem_pkg::SEW_8)), 5'd3,
                  $urandom);
        wb_write(elem_pkg::REG_CTRL, ctrl_word(elem_pkg::RED_MAX, elem_pkg::SEW_32, 5'd4, 1'b1));
        wait_job(res_a);
        repeat (VREG_W / 8 + 20) @(negedge clk);
        compare_value("write-back count", 32'(wb_seen), 32'(jobs_issued));
        read_expect(elem_pkg::REG_CTRL, ctrl_word(elem_pkg::RED_SUM, elem_pkg::SEW_8, 5'd3, 1'b0),
                    "CTRL after ignored start");

        // back-to-back jobs on different source registers
        run_job(elem_pkg::RED_OR, elem_pkg::SEW_32, 8'd4, 5'd5, $urandom, res_a);
        run_job(elem_pkg::RED_AND, elem_pkg::SEW_16, 8'd8, 5'd17, $urandom, res_a);
        run_job(elem_pkg::RED_SUM, elem_pkg::SEW_8, 8'd16, 5'd9, $urandom, res_a);
        run_job(elem_pkg::RED_MAX, elem_pkg::SEW_32, 8'd3, 5'd26, $urandom, res_a);

        if (exp_res.size() != 0) begin
            $display("%0d jobs ended without a scalar write-back", exp_res.size());
            errors++;
        end
        $display("elem_tb finished with %0d checks and %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== test/elem_tb_clock.sv ====
// clock and reset source for the reduction unit testbench
// reset is low for RST_CYCLES clock periods from time zero

module elem_tb_clock #(
    parameter int unsigned PERIOD     = 8,
    parameter int unsigned RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // release lands on a falling edge, away from the active edge
    initial begin
        rst_n_o = 1'b0;
        #(PERIOD * RST_CYCLES);
        rst_n_o = 1'b1;
    end

endmodule

// ==== logic/elem_unit_top.sv ====
// top level of the vector element reduction unit
// host programs it over Wishbone, the source register comes from an external file

module elem_unit_top #(
    parameter int unsigned VREG_W = 128
) (
    input  logic                                clk_i,
    input  logic                                async_rst_ni,

    input  elem_pkg::wb_req_t                   wb_req_i,
    output elem_pkg::wb_rsp_t                   wb_rsp_o,

    output logic [elem_pkg::VREG_ADDR_W-1:0]    vreg_rd_addr_o,
    input  logic [VREG_W-1:0]                   vreg_rd_i,

    output logic                                xreg_valid_o,
    output logic [elem_pkg::XLEN-1:0]           xreg_o
);

    logic                  start;
    elem_pkg::elem_cfg_t   cfg;
    logic                  beat_valid;
    elem_pkg::elem_beat_t  beat;

    elem_cfg_regs #(
        .VREG_W       (VREG_W)
    ) cfg_regs_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .wb_req_i     (wb_req_i),
        .wb_rsp_o     (wb_rsp_o),
        .start_o      (start),
        .cfg_o        (cfg),
        .res_valid_i  (xreg_valid_o),
        .res_i        (xreg_o)
    );

    elem_operand_shift #(
        .VREG_W         (VREG_W)
    ) operand_shift_i (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .start_i        (start),
        .cfg_i          (cfg),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .vreg_rd_i      (vreg_rd_i),
        .beat_valid_o   (beat_valid),
        .beat_o         (beat)
    );

    // write-back pulse also feeds the status and result registers
    elem_reduce_alu reduce_alu_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .cfg_i        (cfg),
        .beat_valid_i (beat_valid),
        .beat_i       (beat),
        .res_valid_o  (xreg_valid_o),
        .res_o        (xreg_o)
    );

endmodule

// ==== logic/elem_reduce_alu.sv ====
// folds the streamed elements into a scalar accumulator
// the result is published for one cycle after the last beat

module elem_reduce_alu (
    input  logic                          clk_i,
    input  logic                          async_rst_ni,

    input  elem_pkg::elem_cfg_t           cfg_i,

    input  logic                          beat_valid_i,
    input  elem_pkg::elem_beat_t          beat_i,

    output logic                          res_valid_o,
    output logic [elem_pkg::XLEN-1:0]     res_o
);

    // sign-extend the low SEW bits to the full width
    function automatic logic [31:0] sext(input logic [31:0] x, input elem_pkg::elem_sew_e sew);
        case (sew)
            elem_pkg::SEW_8:  return {{24{x[7]}}, x[7:0]};
            elem_pkg::SEW_16: return {{16{x[15]}}, x[15:0]};
            default:          return x;
        endcase
    endfunction

    logic [31:0] acc_q;
    logic [31:0] acc_d;
    logic [31:0] base;
    logic [31:0] mask;
    logic [31:0] lo_base;
    logic [31:0] lo_elem;
    logic [31:0] sx_base;
    logic [31:0] sx_elem;
    logic [31:0] op_res;
    logic        first_q;
    logic        res_valid_q;

    always_comb begin
        case (cfg_i.sew)
            elem_pkg::SEW_8:  mask = 32'h0000_00ff;
            elem_pkg::SEW_16: mask = 32'h0000_ffff;
            elem_pkg::SEW_32: mask = 32'hffff_ffff;
            default:          mask = 32'h0000_0000;
        endcase
    end

    // first beat of a job starts from the programmed init value
    assign base    = first_q ? cfg_i.init : acc_q;
    assign lo_base = base & mask;
    assign lo_elem = beat_i.elem & mask;
    assign sx_base = sext(base, cfg_i.sew);
    assign sx_elem = sext(beat_i.elem, cfg_i.sew);

    ////////////////////////////////////////
    // reduction operators

    always_comb begin
        case (cfg_i.op)
            elem_pkg::RED_SUM:  op_res = lo_base + lo_elem;
            elem_pkg::RED_AND:  op_res = lo_base & lo_elem;
            elem_pkg::RED_OR:   op_res = lo_base | lo_elem;
            elem_pkg::RED_XOR:  op_res = lo_base ^ lo_elem;
            elem_pkg::RED_MINU: op_res = (lo_elem < lo_base) ? lo_elem : lo_base;
            elem_pkg::RED_MIN:  op_res = ($signed(sx_elem) < $signed(sx_base)) ? lo_elem : lo_base;
            elem_pkg::RED_MAXU: op_res = (lo_elem > lo_base) ? lo_elem : lo_base;
            elem_pkg::RED_MAX:  op_res = ($signed(sx_elem) > $signed(sx_base)) ? lo_elem : lo_base;
            default:            op_res = lo_base;
        endcase
        // sum wraps at SEW bits, bits above SEW keep the init value
        acc_d = beat_i.active ? ((op_res & mask) | (base & ~mask)) : base;
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            first_q     <= 1'b1;
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= beat_valid_i & beat_i.last;
            if (beat_valid_i) begin
                first_q <= beat_i.last;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (beat_valid_i) begin
            acc_q <= acc_d;
        end
    end

    assign res_valid_o = res_valid_q;
    assign res_o       = acc_q;

    // width comes from the host register and must be one of the three legal codes
    a_legal_sew: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        beat_valid_i |-> cfg_i.sew inside {elem_pkg::SEW_8, elem_pkg::SEW_16, elem_pkg::SEW_32}
    );

endmodule

// ==== logic/elem_operand_shift.sv ====
// fetches the source vector register and streams it out one element per cycle
// each beat carries the zero-extended element, its vl flag and the last flag

module elem_operand_shift #(
    parameter int unsigned VREG_W = 128
) (
    input  logic                                clk_i,
    input  logic                                async_rst_ni,

    input  logic                                start_i,
    input  elem_pkg::elem_cfg_t                 cfg_i,

    output logic [elem_pkg::VREG_ADDR_W-1:0]    vreg_rd_addr_o,
    input  logic [VREG_W-1:0]                   vreg_rd_i,

    output logic                                beat_valid_o,
    output elem_pkg::elem_beat_t                beat_o
);

    // enough bits to count the bytes of one register
    localparam int unsigned IDX_W = $clog2(VREG_W / 8);

    elem_pkg::elem_cfg_t  job_q;
    logic                 load_q;
    logic                 stream_q;
    logic [VREG_W-1:0]    shift_q;
    logic [IDX_W-1:0]     idx_q;
    logic [IDX_W-1:0]     last_idx;
    logic                 last_beat;

    // address goes out in the start cycle, data comes back one cycle later
    assign vreg_rd_addr_o = start_i ? cfg_i.vs : job_q.vs;

    // index of the final element: VREG_W/SEW - 1
    always_comb begin
        case (job_q.sew)
            elem_pkg::SEW_16: last_idx = {IDX_W{1'b1}} >> 1;
            elem_pkg::SEW_32: last_idx = {IDX_W{1'b1}} >> 2;
            default:          last_idx = {IDX_W{1'b1}};
        endcase
    end

    assign last_beat = idx_q == last_idx;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            load_q   <= 1'b0;
            stream_q <= 1'b0;
            idx_q    <= '0;
        end else begin
            load_q <= start_i;
            if (load_q) begin
                stream_q <= 1'b1;
                idx_q    <= '0;
            end else if (stream_q) begin
                idx_q <= idx_q + 1'b1;
                if (last_beat) begin
                    stream_q <= 1'b0;
                end
            end
        end
    end

    // job latch and operand shift register
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            job_q <= cfg_i;
        end
        if (load_q) begin
            shift_q <= vreg_rd_i;
        end else if (stream_q) begin
            case (job_q.sew)
                elem_pkg::SEW_16: shift_q <= shift_q >> 16;
                elem_pkg::SEW_32: shift_q <= shift_q >> 32;
                default:          shift_q <= shift_q >> 8;
            endcase
        end
    end

    always_comb begin
        case (job_q.sew)
            elem_pkg::SEW_16: beat_o.elem = {16'b0, shift_q[15:0]};
            elem_pkg::SEW_32: beat_o.elem = shift_q[31:0];
            default:          beat_o.elem = {24'b0, shift_q[7:0]};
        endcase
        beat_o.active = 32'(idx_q) < 32'(job_q.vl);
        beat_o.last   = last_beat;
    end

    assign beat_valid_o = stream_q;

    // the register block must hold off a new job until this one is drained
    a_no_start_busy: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        start_i |-> !(load_q || stream_q)
    );

endmodule

// ==== logic/elem_cfg_regs.sv ====
// Wishbone classic slave with the job configuration, status and result registers
// a write to CTRL with bit 31 set launches a job when the unit is idle

module elem_cfg_regs #(
    parameter int unsigned VREG_W = 128
) (
    input  logic                          clk_i,
    input  logic                          async_rst_ni,

    input  elem_pkg::wb_req_t             wb_req_i,
    output elem_pkg::wb_rsp_t             wb_rsp_o,

    output logic                          start_o,
    output elem_pkg::elem_cfg_t           cfg_o,

    input  logic                          res_valid_i,
    input  logic [elem_pkg::XLEN-1:0]     res_i
);

    if ((VREG_W & (VREG_W - 1)) != 0 || VREG_W < 64 || VREG_W > 1024) begin : g_vreg_w_check
        $fatal(1, "VREG_W must be a power of two from 64 to 1024, got %0d", VREG_W);
    end

    elem_pkg::elem_cfg_t         cfg_q;
    logic                        busy_q;
    logic                        done_q;
    logic                        ack_q;
    logic                        start_q;
    logic [elem_pkg::XLEN-1:0]   result_q;
    logic [elem_pkg::XLEN-1:0]   rdata_q;

    logic req;
    logic wr;

    // one access per strobe, the ack cycle itself is not a new request
    assign req = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    // configuration is locked while a job runs
    assign wr  = req & wb_req_i.we & ~busy_q;

    ////////////////////////////////////////
    // register writes and job control

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            cfg_q    <= '0;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            ack_q    <= 1'b0;
            start_q  <= 1'b0;
            result_q <= '0;
        end else begin
            ack_q   <= req;
            start_q <= 1'b0;
            if (wr) begin
                case (wb_req_i.adr)
                    elem_pkg::REG_CTRL: begin
                        cfg_q.op  <= elem_pkg::elem_op_e'(wb_req_i.dat[3:0]);
                        cfg_q.sew <= elem_pkg::elem_sew_e'(wb_req_i.dat[5:4]);
                        cfg_q.vs  <= wb_req_i.dat[12:8];
                        if (wb_req_i.dat[31]) begin
                            start_q <= 1'b1;
                            busy_q  <= 1'b1;
                            done_q  <= 1'b0;
                        end
                    end
                    elem_pkg::REG_VL:   cfg_q.vl   <= wb_req_i.dat[7:0];
                    elem_pkg::REG_INIT: cfg_q.init <= wb_req_i.dat;
                    default: ;
                endcase
            end
            // job finished, result arrives together with the write-back pulse
            if (res_valid_i) begin
                busy_q   <= 1'b0;
                done_q   <= 1'b1;
                result_q <= res_i;
            end
        end
    end

    ////////////////////////////////////////
    // read path, data valid with ack

    always_ff @(posedge clk_i) begin
        if (req) begin
            case (wb_req_i.adr)
                elem_pkg::REG_CTRL:   rdata_q <= {19'b0, cfg_q.vs, 2'b0, cfg_q.sew, cfg_q.op};
                elem_pkg::REG_VL:     rdata_q <= {24'b0, cfg_q.vl};
                elem_pkg::REG_INIT:   rdata_q <= cfg_q.init;
                elem_pkg::REG_RESULT: rdata_q <= result_q;
                elem_pkg::REG_STATUS: rdata_q <= {30'b0, done_q, busy_q};
                default:              rdata_q <= '0;
            endcase
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdata_q;
    assign start_o      = start_q;
    assign cfg_o        = cfg_q;

    // the master keeps stb up until it sees ack
    a_ack_with_stb: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        wb_rsp_o.ack |-> wb_req_i.stb
    );

    // a write-back only ever ends a job that is still running
    a_result_while_busy: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        res_valid_i |-> busy_q
    );

endmodule

// ==== logic/elem_pkg.sv ====
// shared types and constants of the vector element reduction unit
// every file refers to these through elem_pkg:: scoped names

package elem_pkg;

    parameter int unsigned XLEN        = 32;
    parameter int unsigned VREG_ADDR_W = 5;
    parameter int unsigned WB_ADR_W    = 8;

    // register map, byte offsets on the Wishbone bus
    parameter logic [WB_ADR_W-1:0] REG_CTRL   = 8'h00;
    parameter logic [WB_ADR_W-1:0] REG_VL     = 8'h04;
    parameter logic [WB_ADR_W-1:0] REG_INIT   = 8'h08;
    parameter logic [WB_ADR_W-1:0] REG_RESULT = 8'h0C;
    parameter logic [WB_ADR_W-1:0] REG_STATUS = 8'h10;

    typedef enum logic [3:0] {
        RED_SUM  = 4'd0,
        RED_AND  = 4'd1,
        RED_OR   = 4'd2,
        RED_XOR  = 4'd3,
        RED_MINU = 4'd4,
        RED_MIN  = 4'd5,
        RED_MAXU = 4'd6,
        RED_MAX  = 4'd7
    } elem_op_e;

    // code 2'b11 is not a legal width
    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10
    } elem_sew_e;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [XLEN-1:0]     dat;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] dat;
    } wb_rsp_t;

    // one reduction job as programmed by the host
    typedef struct packed {
        elem_op_e               op;
        elem_sew_e              sew;
        logic [7:0]             vl;
        logic [VREG_ADDR_W-1:0] vs;
        logic [XLEN-1:0]        init;
    } elem_cfg_t;

    // element zero-extended to XLEN, plus its vl and end-of-register flags
    typedef struct packed {
        logic [XLEN-1:0] elem;
        logic            active;
        logic            last;
    } elem_beat_t;

endpackage
